// File: tb.f
logic/busSizePkg.sv
logic/cycleSplitter.sv
logic/laneSteer.sv
logic/busSizer.sv
tb/busSizerTb.sv

// File: run.sh
#!/bin/sh
# Build and run the bus sizer testbench with Verilator

rm -rf obj_dir
verilator --binary --timing --assert --top-module busSizerTb -f tb.f \
    -o busSizerSim > build.log 2>&1 \
    || { echo "Build failed, see build.log"; exit 1; }

./obj_dir/busSizerSim > sim.log 2>&1

grep -q "^Done: no errors$" sim.log \
    && echo "PASS" \
    || { echo "FAIL, see sim.log"; exit 1; }

// File: tb/busSizerTb.sv
/*
 Testbench for the dynamic bus sizer
 Clock, reset, LFSR, random requests, bus target model, reference model,
 checks and watchdog
*/

module busSizerTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int clkPeriod = 20;
    localparam int numReqs   = 300;

    // One expected bus cycle with wdata compared under wmask
    typedef struct packed {
        logic [31:0] addr;
        logic [3:0]  lanes;
        logic        write;
        logic [31:0] wdata;
        logic [31:0] wmask;
    } expCycle_t;

    logic                  BCLK;
    logic                  nRESET;
    logic                  reqValid;
    logic                  reqReady;
    busSizePkg::cpuReq_t   req;
    logic                  rspValid;
    logic                  rspReady;
    logic [31:0]           rspData;
    logic                  busValid;
    busSizePkg::busCycle_t busCycle;
    busSizePkg::busTerm_t  term;
    logic [31:0]           busRdata;

    logic [15:0] lfsrState = 16'd20;
    logic [31:0] mem [16];
    expCycle_t   expQ [$];
    // Port width of the target for the running request
    logic        portWord = 1'b0;
    int          errors = 0;

    busSizer busSizer_i (
        .BCLK     (BCLK),
        .nRESET   (nRESET),
        .reqValid (reqValid),
        .reqReady (reqReady),
        .req      (req),
        .rspValid (rspValid),
        .rspReady (rspReady),
        .rspData  (rspData),
        .busValid (busValid),
        .busCycle (busCycle),
        .term     (term),
        .busRdata (busRdata)
    );

    ////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////

    initial begin
        BCLK = 1'b0;
        forever #(clkPeriod / 2) BCLK = ~BCLK;
    end

    // Budget of 20 cycles per request plus reset
    initial begin
        #((numReqs * 20 + 16) * clkPeriod);
        $display("Watchdog expired before all requests completed, errors %0d", errors);
        $display("Done: errors found");
        $finish;
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////

    // Galois LFSR stepped once per bit
    function automatic logic stepLfsr();
        logic outBit;
        outBit = lfsrState[0];
        lfsrState = lfsrState >> 1;
        if (outBit) begin
            lfsrState = lfsrState ^ 16'hB400;
        end
        return outBit;
    endfunction

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], stepLfsr()};
        end
        return v;
    endfunction

    // Lane enable to bit mask with lanes bit 3 on bits 31:24
    function automatic logic [31:0] laneMask(input logic [3:0] lanes);
        logic [31:0] m;
        m = '0;
        for (int k = 0; k < 4; k++) begin
            if (lanes[3-k]) begin
                m[31-8*k -: 8] = 8'hFF;
            end
        end
        return m;
    endfunction

    task automatic checkValue(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            errors++;
            $display("Mismatch %s: got %h expected %h", name, got, exp);
        end
    endtask

    ////////////////////////////////////////
    // Bus target
    ////////////////////////////////////////

    // Word port drives upper lanes and junk on the lower lanes
    function automatic logic [31:0] readBus();
        logic [31:0] word;
        logic [31:0] junk;
        word = mem[busCycle.addr[5:2]];
        if (!portWord) begin
            return word;
        end
        junk = randBits(16);
        return {(busCycle.addr[1] ? word[15:0] : word[31:16]), junk[15:0]};
    endfunction

    task automatic completeCycle();
        expCycle_t e;
        int k;
        if (expQ.size() == 0) begin
            errors++;
            $display("Bus cycle seen that the request does not call for");
            return;
        end
        e = expQ.pop_front();
        checkValue("busCycle.addr", busCycle.addr, e.addr);
        checkValue("busCycle.lanes", 32'(busCycle.lanes), 32'(e.lanes));
        checkValue("busCycle.write", 32'(busCycle.write), 32'(e.write));
        if (busCycle.write) begin
            checkValue("busCycle.wdata", busCycle.wdata & e.wmask, e.wdata);
            for (int j = 0; j < 4; j++) begin
                // Word port maps upper lanes onto the addressed half
                k = portWord ? (busCycle.addr[1] ? 2 : 0) + j : j;
                if ((!portWord || j < 2) && busCycle.lanes[3-k]) begin
                    mem[busCycle.addr[5:2]][31-8*k -: 8] = busCycle.wdata[31-8*j -: 8];
                end
            end
        end
    endtask

    initial begin : busTarget
        int   waitsLeft;
        logic inCycle;
        term      = busSizePkg::termWait;
        busRdata  = '0;
        inCycle   = 1'b0;
        waitsLeft = 0;
        forever begin
            @(posedge BCLK);
            if (nRESET && busValid && term != busSizePkg::termWait) begin
                completeCycle();
                inCycle = 1'b0;
            end
            #2;
            if (busValid) begin
                if (!inCycle) begin
                    inCycle   = 1'b1;
                    waitsLeft = int'(randBits(2));
                end
                if (waitsLeft > 0) begin
                    term     = busSizePkg::termWait;
                    busRdata = randBits(32);
                    waitsLeft--;
                end else begin
                    term     = portWord ? busSizePkg::termWord : busSizePkg::termLong;
                    busRdata = readBus();
                end
            end else begin
                term = busSizePkg::termWait;
            end
        end
    end

    ////////////////////////////////////////
    // Request driver and reference model
    ////////////////////////////////////////

    task automatic runRequest();
        busSizePkg::xferSize_t size;
        logic [31:0] addr;
        logic [31:0] wdata;
        logic [31:0] tmp;
        logic [31:0] mask;
        logic [31:0] expRead;
        logic [31:0] heldData;
        logic [3:0]  lanes;
        logic        wr;
        logic        stalled;
        logic        taken;
        int          nBytes;
        expCycle_t   e;
        tmp  = randBits(2);
        size = busSizePkg::xferSize_t'(tmp[1:0]);
        tmp  = randBits(4);
        addr = {26'd0, tmp[3:0], 2'b00};
        if (size == busSizePkg::sizeWord) begin
            tmp = randBits(1);
            addr[1] = tmp[0];
        end else if (size == busSizePkg::sizeByte) begin
            tmp = randBits(2);
            addr[1:0] = tmp[1:0];
        end
        tmp      = randBits(1);
        wr       = tmp[0];
        wdata    = randBits(32);
        tmp      = randBits(1);
        portWord = tmp[0];

        // Lanes covered from the first byte offset for the transfer length
        case (size)
            busSizePkg::sizeByte: nBytes = 1;
            busSizePkg::sizeWord: nBytes = 2;
            default:              nBytes = 4;
        endcase
        for (int k = 0; k < 4; k++) begin
            lanes[3-k] = (k >= int'(addr[1:0])) && (k < int'(addr[1:0]) + nBytes);
        end
        mask    = laneMask(lanes);
        expRead = mem[addr[5:2]] & mask;

        if (lanes == 4'b1111 && portWord) begin
            // Split long sends the upper word and then the lower word
            expQ.push_back({addr, lanes, wr, {wdata[31:16], 16'h0}, 32'hFFFF0000});
            expQ.push_back({addr + 32'd2, lanes, wr, {wdata[15:0], 16'h0}, 32'hFFFF0000});
        end else if (!portWord) begin
            expQ.push_back({addr, lanes, wr, wdata & mask, mask});
        end else begin
            e = {addr, lanes, wr, 32'h0, 32'h0};
            for (int k = 0; k < 4; k++) begin
                if (lanes[3-k]) begin
                    e.wdata[31-8*(k%2) -: 8] = wdata[31-8*k -: 8];
                    e.wmask[31-8*(k%2) -: 8] = 8'hFF;
                end
            end
            expQ.push_back(e);
        end

        reqValid   = 1'b1;
        req.addr   = addr;
        req.size   = size;
        req.write  = wr;
        req.wdata  = wdata;
        do begin
            @(posedge BCLK);
        end while (!reqReady);
        #2;
        reqValid = 1'b0;
        checkValue("busValid", 32'(busValid), 32'd0);
        checkValue("reqReady", 32'(reqReady), 32'd0);
        @(posedge BCLK);
        #2;
        checkValue("busValid", 32'(busValid), 32'd1);

        // Response with random back-pressure
        stalled = 1'b0;
        taken   = 1'b0;
        heldData = '0;
        while (!taken) begin
            tmp      = randBits(1);
            rspReady = tmp[0];
            @(posedge BCLK);
            if (rspValid) begin
                if (stalled) begin
                    checkValue("rspData", rspData, heldData);
                end
                if (rspReady) begin
                    taken = 1'b1;
                end else begin
                    stalled  = 1'b1;
                    heldData = rspData;
                end
            end else if (stalled) begin
                errors++;
                $display("Response valid dropped while the processor stalled it");
            end
            #2;
        end
        rspReady = 1'b0;
        checkValue("rspValid", 32'(rspValid), 32'd0);
        if (!wr) begin
            checkValue("rspData", rspData & mask, expRead);
        end
        if (expQ.size() != 0) begin
            errors++;
            $display("Response returned before all bus cycles ran");
            expQ.delete();
        end
    endtask

    initial begin : mainFlow
        nRESET   = 1'b0;
        reqValid = 1'b0;
        req      = '0;
        rspReady = 1'b0;
        // Distinct pattern for every long word
        for (int i = 0; i < 16; i++) begin
            mem[i] = (i * 32'h0103_0507) ^ 32'h5A3C_96E1;
        end
        repeat (16) @(posedge BCLK);
        #2;
        nRESET = 1'b1;
        @(posedge BCLK);
        #2;
        checkValue("reqReady", 32'(reqReady), 32'd1);
        checkValue("busValid", 32'(busValid), 32'd0);
        checkValue("rspValid", 32'(rspValid), 32'd0);
        for (int n = 0; n < numReqs; n++) begin
            runRequest();
        end
        $display("Requests %0d, errors %0d", numReqs, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

// File: logic/busSizer.sv
/*
 Dynamic bus sizer top level
 Splitter and lane steering between processor and bus ports
*/

module busSizer (
    input  logic                                 BCLK,
    input  logic                                 nRESET,
    // Processor request
    input  logic                                 reqValid,
    output logic                                 reqReady,
    input  busSizePkg::cpuReq_t                  req,
    // Processor response
    output logic                                 rspValid,
    input  logic                                 rspReady,
    output logic [busSizePkg::dataWidth-1:0]     rspData,
    // External bus
    output logic                                 busValid,
    output busSizePkg::busCycle_t                busCycle,
    input  busSizePkg::busTerm_t                 term,
    input  logic [busSizePkg::dataWidth-1:0]     busRdata
);

    logic [busSizePkg::dataWidth-1:0] busAddr;
    logic [busSizePkg::laneCount-1:0] busLanes;
    logic                             busWrite;
    logic [busSizePkg::dataWidth-1:0] busWdata;
    logic                             secondHalf;
    logic                             captureUpper;
    logic                             captureFinal;
    logic [1:0]                       reqAddrLow;
    busSizePkg::xferSize_t            reqSize;
    logic [busSizePkg::dataWidth-1:0] reqWdata;

    ////////////////////////////////////////
    // Sequencing
    ////////////////////////////////////////

    cycleSplitter splitter (
        .BCLK         (BCLK),
        .nRESET       (nRESET),
        .reqValid     (reqValid),
        .reqReady     (reqReady),
        .req          (req),
        .rspValid     (rspValid),
        .rspReady     (rspReady),
        .busValid     (busValid),
        .busAddr      (busAddr),
        .busLanes     (busLanes),
        .busWrite     (busWrite),
        .term         (term),
        .secondHalf   (secondHalf),
        .captureUpper (captureUpper),
        .captureFinal (captureFinal),
        .reqAddrLow   (reqAddrLow),
        .reqSize      (reqSize),
        .reqWdata     (reqWdata)
    );

    ////////////////////////////////////////
    // Data lanes
    ////////////////////////////////////////

    laneSteer steer (
        .BCLK         (BCLK),
        .nRESET       (nRESET),
        .reqWdata     (reqWdata),
        .reqAddrLow   (reqAddrLow),
        .reqSize      (reqSize),
        .secondHalf   (secondHalf),
        .captureUpper (captureUpper),
        .captureFinal (captureFinal),
        .term         (term),
        .busRdata     (busRdata),
        .busWdata     (busWdata),
        .rspData      (rspData)
    );

    // Bus cycle bundle
    assign busCycle.addr  = busAddr;
    assign busCycle.lanes = busLanes;
    assign busCycle.write = busWrite;
    assign busCycle.wdata = busWdata;

endmodule

// File: logic/laneSteer.sv
/*
 Byte lane steering between processor and bus
 Write replication, read steering, upper-word hold and response register
*/

module laneSteer (
    input  logic                                 BCLK,
    input  logic                                 nRESET,
    // Held request fields
    input  logic [busSizePkg::dataWidth-1:0]     reqWdata,
    input  logic [1:0]                           reqAddrLow,
    input  busSizePkg::xferSize_t                reqSize,
    // From the splitter
    input  logic                                 secondHalf,
    input  logic                                 captureUpper,
    input  logic                                 captureFinal,
    // Bus read side
    input  busSizePkg::busTerm_t                 term,
    input  logic [busSizePkg::dataWidth-1:0]     busRdata,
    // Outputs
    output logic [busSizePkg::dataWidth-1:0]     busWdata,
    output logic [busSizePkg::dataWidth-1:0]     rspData
);

    localparam int halfWidth = busSizePkg::dataWidth / 2;

    logic                 isLongSize;
    // Processor lower word in play
    logic                 useLowWord;
    logic [halfWidth-1:0] busUpper;
    logic [halfWidth-1:0] upperHold;
    logic [busSizePkg::dataWidth-1:0] steered;

    assign isLongSize = (reqSize == busSizePkg::sizeLong) ||
                        (reqSize == busSizePkg::sizeLine);

    // Lower word at addr bit 1, or second half of a split long
    assign useLowWord = secondHalf || (!isLongSize && reqAddrLow[1]);

    // Word port answers on lanes 0 and 1
    assign busUpper = busRdata[busSizePkg::dataWidth-1:halfWidth];

    ////////////////////////////////////////
    // Write path
    ////////////////////////////////////////

    // Copy lower word up so a word port sees it on lanes 0 and 1
    // Lower lanes keep it too for a long port
    always_comb begin
        if (useLowWord) begin
            busWdata = {reqWdata[halfWidth-1:0], reqWdata[halfWidth-1:0]};
        end else begin
            busWdata = reqWdata;
        end
    end

    ////////////////////////////////////////
    // Read path
    ////////////////////////////////////////

    always_comb begin
        case (term)
            busSizePkg::termLong: begin
                // Full port, lanes line up
                steered = busRdata;
            end
            busSizePkg::termWord, busSizePkg::termByte: begin
                if (secondHalf) begin
                    // Join held first half with this one
                    steered = {upperHold, busUpper};
                end else begin
                    // Both halves carry the word, addr bit 1 picks one
                    steered = {busUpper, busUpper};
                end
            end
            default: begin
                // Waiting, nothing captured
                steered = busRdata;
            end
        endcase
    end

    // First half of a split read
    always_ff @(posedge BCLK) begin
        if (captureUpper) begin
            upperHold <= busUpper;
        end
    end

    // Response data, held through back-pressure
    always_ff @(posedge BCLK) begin
        if (captureFinal) begin
            rspData <= steered;
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // Splitter never asks for both captures at once
    oneCapture: assert property (@(posedge BCLK) disable iff (!nRESET)
        !(captureUpper && captureFinal))
        else $error("upper and final capture in same cycle");

    // Split halves only on a long
    splitIsLong: assert property (@(posedge BCLK) disable iff (!nRESET)
        (captureUpper || secondHalf) |-> isLongSize)
        else $error("split cycle for a non-long request");

endmodule

// File: logic/cycleSplitter.sv
/*
 Request register and bus cycle sequencing
 Lane enable decode, one or two cycles per request, capture strobes
*/

module cycleSplitter (
    input  logic                                 BCLK,
    input  logic                                 nRESET,
    // Processor request
    input  logic                                 reqValid,
    output logic                                 reqReady,
    input  busSizePkg::cpuReq_t                  req,
    // Processor response handshake
    output logic                                 rspValid,
    input  logic                                 rspReady,
    // External bus cycle
    output logic                                 busValid,
    output logic [busSizePkg::dataWidth-1:0]     busAddr,
    output logic [busSizePkg::laneCount-1:0]     busLanes,
    output logic                                 busWrite,
    input  busSizePkg::busTerm_t                 term,
    // To the lane steering
    output logic                                 secondHalf,
    output logic                                 captureUpper,
    output logic                                 captureFinal,
    output logic [1:0]                           reqAddrLow,
    output busSizePkg::xferSize_t                reqSize,
    output logic [busSizePkg::dataWidth-1:0]     reqWdata
);

    busSizePkg::sizerState_t state;
    busSizePkg::cpuReq_t     reqHeld;
    // Low for the settle cycle on entry to each state
    logic                    live;
    logic                    isLong;
    logic                    termDone;
    logic                    splitNow;

    ////////////////////////////////////////
    // Request register
    ////////////////////////////////////////

    // Loaded at acceptance, held until the response leaves
    always_ff @(posedge BCLK) begin
        if (reqValid && reqReady) begin
            reqHeld <= req;
        end
    end

    assign reqAddrLow = reqHeld.addr[1:0];
    assign reqSize    = reqHeld.size;
    assign reqWdata   = reqHeld.wdata;

    // Line runs as a plain long
    assign isLong = (reqHeld.size == busSizePkg::sizeLong) ||
                    (reqHeld.size == busSizePkg::sizeLine);

    ////////////////////////////////////////
    // Bus cycle outputs
    ////////////////////////////////////////

    assign reqReady   = (state == busSizePkg::stIdle);
    assign secondHalf = (state == busSizePkg::stSecond);
    assign busValid   = live && ((state == busSizePkg::stFirst) || secondHalf);
    assign rspValid   = live && (state == busSizePkg::stRespond);
    assign busWrite   = reqHeld.write;

    // Second half of a split long goes to the lower word
    assign busAddr = secondHalf ? reqHeld.addr + 32'd2 : reqHeld.addr;

    // Lane enables from size and address bits 1:0
    always_comb begin
        case (reqHeld.size)
            busSizePkg::sizeLong, busSizePkg::sizeLine: begin
                busLanes = {busSizePkg::laneCount{1'b1}};
            end
            busSizePkg::sizeWord: begin
                // Upper pair or lower pair
                busLanes = reqHeld.addr[1] ? 4'b0011 : 4'b1100;
            end
            default: begin
                // Single byte, lane 0 at bit 3
                busLanes = 4'b1000 >> reqHeld.addr[1:0];
            end
        endcase
    end

    ////////////////////////////////////////
    // Termination decode
    ////////////////////////////////////////

    // Any code but termWait ends the running cycle
    assign termDone = busValid && (term != busSizePkg::termWait);

    // Long on a word port in its first half needs a second cycle
    assign splitNow = termDone && (state == busSizePkg::stFirst) && isLong &&
                      (term == busSizePkg::termWord);

    // Strobes valid at the termination edge
    assign captureUpper = splitNow;
    assign captureFinal = termDone && !splitNow;

    ////////////////////////////////////////
    // FSM
    ////////////////////////////////////////

    always_ff @(posedge BCLK or negedge nRESET) begin
        if (!nRESET) begin
            state <= busSizePkg::stIdle;
            live  <= 1'b0;
        end else begin
            case (state)
                busSizePkg::stIdle: begin
                    live <= 1'b0;
                    if (reqValid) begin
                        state <= busSizePkg::stFirst;
                    end
                end
                busSizePkg::stFirst, busSizePkg::stSecond: begin
                    if (!live) begin
                        // Start the bus cycle after the gap
                        live <= 1'b1;
                    end else if (termDone) begin
                        live  <= 1'b0;
                        state <= splitNow ? busSizePkg::stSecond : busSizePkg::stRespond;
                    end
                end
                busSizePkg::stRespond: begin
                    if (!live) begin
                        live <= 1'b1;
                    end else if (rspReady) begin
                        // Response taken, back to idle
                        live  <= 1'b0;
                        state <= busSizePkg::stIdle;
                    end
                end
                default: begin
                    state <= busSizePkg::stIdle;
                    live  <= 1'b0;
                end
            endcase
        end
    end

    ////////////////////////////////////////
    // Checks
    ////////////////////////////////////////

    // No byte-wide target on this bus
    noByteTerm: assert property (@(posedge BCLK) disable iff (!nRESET)
        busValid |-> (term != busSizePkg::termByte))
        else $error("byte port termination seen on bus");

    // Word requests are word aligned
    wordAligned: assert property (@(posedge BCLK) disable iff (!nRESET)
        (reqValid && reqReady && (req.size == busSizePkg::sizeWord)) |-> !req.addr[0])
        else $error("word request on odd address");

    // Cycle held steady across wait states
    stableOnWait: assert property (@(posedge BCLK) disable iff (!nRESET)
        (busValid && (term == busSizePkg::termWait)) |=>
            (busValid && $stable(busAddr) && $stable(busLanes) && $stable(busWrite)))
        else $error("bus cycle changed during wait");

endmodule

// File: logic/busSizePkg.sv
/*
 Shared types of the dynamic bus sizer
 Transfer size and termination codes, request and bus cycle structs,
 splitter FSM states and data path widths
*/

package busSizePkg;

    ////////////////////////////////////////
    // Widths
    ////////////////////////////////////////

    // Processor and bus data width
    localparam int dataWidth = 32;
    // Byte lanes, lane 0 is the most significant byte
    localparam int laneCount = 4;

    ////////////////////////////////////////
    // Encodings
    ////////////////////////////////////////

    // Processor transfer size, native encoding
    typedef enum logic [1:0] {
        sizeLong = 2'b00,
        sizeByte = 2'b01,
        sizeWord = 2'b10,
        sizeLine = 2'b11
    } xferSize_t;

    // Port width termination from the target
    // termByte is decoded but no byte port exists
    typedef enum logic [1:0] {
        termLong = 2'b00,
        termWord = 2'b01,
        termByte = 2'b10,
        termWait = 2'b11
    } busTerm_t;

    // Splitter FSM
    typedef enum logic [1:0] {
        stIdle,
        stFirst,
        stSecond,
        stRespond
    } sizerState_t;

    ////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////

    // One processor request, data bits 31:24 are lane 0
    typedef struct packed {
        logic [dataWidth-1:0] addr;
        xferSize_t            size;
        logic                 write;
        logic [dataWidth-1:0] wdata;
    } cpuReq_t;

    // One external bus cycle, lanes bit 3 is lane 0
    typedef struct packed {
        logic [dataWidth-1:0] addr;
        logic [laneCount-1:0] lanes;
        logic                 write;
        logic [dataWidth-1:0] wdata;
    } busCycle_t;

endpackage
